// ==== logic/pdp8_defines.svh ====
// Word, address and opcode constants for the PDP-8 core, included by RTL and testbench
`ifndef PDP8_DEFINES_SVH
`define PDP8_DEFINES_SVH

`define PDP8_WORD_W     12        // Data word width
`define PDP8_ADDR_W     12        // Address width, one 4K field
`define PDP8_MEM_DEPTH  4096      // Core memory words

// Major opcodes in IR bits 0..2
`define PDP8_OP_AND     3'd0      // Logical AND
`define PDP8_OP_TAD     3'd1      // Two's complement add
`define PDP8_OP_ISZ     3'd2      // Increment and skip if zero
`define PDP8_OP_DCA     3'd3      // Deposit and clear AC
`define PDP8_OP_JMS     3'd4      // Jump to subroutine
`define PDP8_OP_JMP     3'd5      // Jump
`define PDP8_OP_IOT     3'd6      // I/O transfer, no devices here
`define PDP8_OP_OPR     3'd7      // Operate microinstructions

// Zero-page locations that auto-increment on indirect use
`define PDP8_AUTOINX_LO 12'o0010  // First auto-index word
`define PDP8_AUTOINX_HI 12'o0017  // Last auto-index word

`endif

// ==== logic/pdp8_pkg.sv ====
// Shared PDP-8 types for instruction decode and sequencing, imported by the core modules
`include "pdp8_defines.svh"

package pdp8_pkg;

	// Major opcode in bits 0..2
	typedef enum logic [2:0] {
		OP_AND = `PDP8_OP_AND,
		OP_TAD = `PDP8_OP_TAD,
		OP_ISZ = `PDP8_OP_ISZ,
		OP_DCA = `PDP8_OP_DCA,
		OP_JMS = `PDP8_OP_JMS,
		OP_JMP = `PDP8_OP_JMP,
		OP_IOT = `PDP8_OP_IOT,
		OP_OPR = `PDP8_OP_OPR
	} opcode_e;

	// Memory reference layout, bit numbers as in the PDP-8 manuals
	typedef struct packed {
		opcode_e     opcode;    // Bits 0..2
		logic        indirect;  // Bit 3
		logic        page;      // Bit 4, set for current page
		logic [5:11] offset;    // Word within page
	} mri_t;

	// Operate layout, micro bits keep their manual numbers
	typedef struct packed {
		opcode_e     opcode;    // Always OPR here
		logic        group;     // Bit 3, 0 selects group 1
		logic [4:11] micro;     // Microinstruction bits
	} opr_t;

	// One instruction word, decoded by opcode into either view
	typedef union packed {
		mri_t mri;
		opr_t opr;
	} instr_u;

	// Sequencer states, one cycle each
	typedef enum logic [2:0] {
		ST_IDLE,     // Stopped, panel owns memory
		ST_FETCH,    // Read strobe at PC
		ST_DECODE,   // Instruction word arrives
		ST_DEFER,    // Pointer read and wait
		ST_AUTOINX,  // Pointer write-back
		ST_READ,     // Operand read strobe
		ST_EXEC,     // Operand arrives or operate runs
		ST_WRITE     // Result store
	} ctrl_state_e;

endpackage

// ==== logic/pdp8_mem_if.sv ====
// One processor memory access per strobe, shared by the sequencer and the core memory
`timescale 1ns/1ps
`include "pdp8_defines.svh"

interface pdp8_mem_if;

	logic                      req;    // One-cycle access strobe
	logic                      we;     // Write when set with req
	logic [0:`PDP8_ADDR_W-1]   addr;   // Word address
	logic [0:`PDP8_WORD_W-1]   wdata;  // Store data
	logic [0:`PDP8_WORD_W-1]   rdata;  // Valid the cycle after a read strobe

	// Sequencer side
	modport cpu (
		output req,
		output we,
		output addr,
		output wdata,
		input  rdata
	);

	// Core memory side
	modport memory (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

// ==== logic/pdp8_memory.sv ====
// 4K-word core memory with a processor port and a front-panel deposit/examine port
`timescale 1ns/1ps
`include "pdp8_defines.svh"

module pdp8_memory (
	input  logic                    i_clk,
	pdp8_mem_if.memory              mem,
	input  logic                    i_panel_we,     // Deposit strobe
	input  logic [0:`PDP8_ADDR_W-1] i_panel_addr,   // Examine/deposit address
	input  logic [0:`PDP8_WORD_W-1] i_panel_wdata,  // Deposit data
	output logic [0:`PDP8_WORD_W-1] o_panel_rdata,  // Examine data, one cycle late
	input  logic                    i_run           // Core running
);

	logic [0:`PDP8_WORD_W-1] mem_array [0:`PDP8_MEM_DEPTH-1];  // Core words

	logic cpu_wr;  // Processor store this cycle
	logic cpu_rd;  // Processor load this cycle

	assign cpu_wr = mem.req & mem.we;
	assign cpu_rd = mem.req & ~mem.we;

	// Single write port, processor first
	always_ff @(posedge i_clk) begin
		if (cpu_wr) begin
			mem_array[mem.addr] <= mem.wdata;  // Lands at the strobe edge
		end else if (i_panel_we) begin
			mem_array[i_panel_addr] <= i_panel_wdata;  // Front-panel deposit
		end
	end

	// Processor read, held until the next read strobe
	always_ff @(posedge i_clk) begin
		if (cpu_rd) begin
			mem.rdata <= mem_array[mem.addr];
		end
	end

	// Panel examine follows the address every cycle
	always_ff @(posedge i_clk) begin
		o_panel_rdata <= mem_array[i_panel_addr];
	end

	// The panel owns memory only while the sequencer is stopped
	a_panel_idle: assert property (@(posedge i_clk) i_run |-> !i_panel_we)
		else $error("panel deposit while the core is running");

endmodule

// ==== logic/pdp8_operate.sv ====
// Combinational Group 1 and Group 2 operate unit, fed by the sequencer during EXEC
`timescale 1ns/1ps
`include "pdp8_defines.svh"

module pdp8_operate import pdp8_pkg::*; (
	input  instr_u                  i_instr,   // Current IR
	input  logic [0:`PDP8_WORD_W-1] i_ac,      // AC before the instruction
	input  logic                    i_link,    // Link before the instruction
	input  logic [0:`PDP8_WORD_W-1] i_switch,  // Switch register
	output logic [0:`PDP8_WORD_W-1] o_ac,      // New AC
	output logic                    o_link,    // New link
	output logic                    o_skip,    // Skip next word
	output logic                    o_halt     // Stop the sequencer
);

	logic [4:11] micro;  // Micro bits, manual numbering
	logic        is_opr;

	// Group 1 intermediate steps
	logic [0:`PDP8_WORD_W-1] g1_ac_clr;
	logic [0:`PDP8_WORD_W-1] g1_ac_cmp;
	logic                    g1_l_clr;
	logic                    g1_l_cmp;
	logic [0:`PDP8_WORD_W]   g1_lac;     // Link and AC after IAC
	logic [0:`PDP8_WORD_W]   g1_rot;     // After the rotate

	// Group 2 terms
	logic                    g2_cond;    // OR of selected sense tests
	logic                    g2_skip;
	logic [0:`PDP8_WORD_W-1] g2_ac;

	assign micro  = i_instr.opr.micro;
	assign is_opr = (i_instr.opr.opcode == OP_OPR);

	// Group 1 in event order
	always_comb begin
		g1_ac_clr = micro[4] ? '0 : i_ac;                 // CLA
		g1_l_clr  = micro[5] ? 1'b0 : i_link;             // CLL
		g1_ac_cmp = micro[6] ? ~g1_ac_clr : g1_ac_clr;    // CMA
		g1_l_cmp  = micro[7] ? ~g1_l_clr : g1_l_clr;      // CML
		g1_lac    = {g1_l_cmp, g1_ac_cmp} + 13'(micro[11]); // IAC, carry flips link
		case ({micro[8], micro[9], micro[10]})
			3'b100: g1_rot = {g1_lac[12], g1_lac[0:11]};      // RAR
			3'b101: g1_rot = {g1_lac[11:12], g1_lac[0:10]};   // RTR
			3'b010: g1_rot = {g1_lac[1:12], g1_lac[0]};       // RAL
			3'b011: g1_rot = {g1_lac[2:12], g1_lac[0:1]};     // RTL
			default: g1_rot = g1_lac;                         // No rotate
		endcase
	end

	// Group 2, sense tests see the incoming AC
	always_comb begin
		g2_cond = (micro[5] & i_ac[0])          // SMA
			| (micro[6] & (i_ac == '0))         // SZA
			| (micro[7] & i_link);              // SNL
		g2_skip = g2_cond ^ micro[8];           // Bit 8 reverses into SPA SNA SZL SKP
		g2_ac   = micro[4] ? '0 : i_ac;         // CLA after the tests
		if (micro[9]) begin
			g2_ac = g2_ac | i_switch;           // OSR
		end
	end

	// Pick the group result
	always_comb begin
		o_ac   = i_ac;
		o_link = i_link;
		o_skip = 1'b0;
		o_halt = 1'b0;
		if (is_opr && !i_instr.opr.group) begin
			o_ac   = g1_rot[1:12];
			o_link = g1_rot[0];
		end else if (is_opr && !micro[11]) begin
			o_ac   = g2_ac;
			o_skip = g2_skip;
			o_halt = micro[10];                 // HLT
		end
		// Group 3 words fall through unchanged
	end

endmodule

// ==== logic/pdp8_control.sv ====
// Non-pipelined PDP-8 instruction sequencer, driving memory and the operate unit
`timescale 1ns/1ps
`include "pdp8_defines.svh"

module pdp8_control import pdp8_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_start,     // Start strobe, honored in IDLE
	input  logic [0:`PDP8_ADDR_W-1] i_start_pc,  // First instruction address
	pdp8_mem_if.cpu                 mem,
	output instr_u                  o_instr,     // IR to operate unit
	output logic [0:`PDP8_WORD_W-1] o_ac_cur,
	output logic                    o_link_cur,
	input  logic [0:`PDP8_WORD_W-1] i_opr_ac,
	input  logic                    i_opr_link,
	input  logic                    i_opr_skip,
	input  logic                    i_opr_halt,
	output logic                    o_run,
	output logic                    o_halted,
	output logic [0:`PDP8_ADDR_W-1] o_pc
);

	ctrl_state_e state;
	logic        defer_wait;                 // Second DEFER cycle
	logic        halted;
	logic        link;
	logic [0:`PDP8_ADDR_W-1] pc;
	logic [0:`PDP8_WORD_W-1] ac;
	logic [0:`PDP8_ADDR_W-1] ma;             // Memory address
	logic [0:`PDP8_WORD_W-1] mb;             // Incremented pointer or ISZ word
	instr_u                  ir;
	instr_u                  fetched;        // Word arriving in DECODE
	logic [0:`PDP8_ADDR_W-1] direct_ea;
	logic                    is_autoinx;

	// Next state once the effective address is known
	function automatic ctrl_state_e route(opcode_e op);
		case (op)
			OP_AND, OP_TAD, OP_ISZ: return ST_READ;
			OP_DCA, OP_JMS:         return ST_WRITE;
			default:                return ST_FETCH;  // JMP is done
		endcase
	endfunction

	assign fetched    = mem.rdata;
	assign direct_ea  = fetched.mri.page ? {pc[0:4], fetched.mri.offset}
		: {5'b0, fetched.mri.offset};        // Current page or page zero
	assign is_autoinx = (ma >= `PDP8_AUTOINX_LO) && (ma <= `PDP8_AUTOINX_HI);

	// Memory request per state
	always_comb begin
		mem.req   = 1'b0;
		mem.we    = 1'b0;
		mem.addr  = ma;
		mem.wdata = mb;
		case (state)
			ST_FETCH: begin
				mem.req  = 1'b1;
				mem.addr = pc;
			end
			ST_DEFER:   mem.req = !defer_wait;  // Strobe then wait
			ST_READ:    mem.req = 1'b1;
			ST_AUTOINX: begin
				mem.req = 1'b1;
				mem.we  = 1'b1;                  // Pointer write-back
			end
			ST_WRITE: begin
				mem.req = 1'b1;
				mem.we  = 1'b1;
				if (ir.mri.opcode == OP_DCA) begin
					mem.wdata = ac;
				end else if (ir.mri.opcode == OP_JMS) begin
					mem.wdata = pc;              // Return address
				end
			end
			default: ;
		endcase
	end

	// Sequencer and architectural registers
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ST_IDLE;
			defer_wait <= 1'b0;
			halted     <= 1'b0;
			pc         <= '0;
			ac         <= '0;
			link       <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (i_start) begin
					pc     <= i_start_pc;
					halted <= 1'b0;
					state  <= ST_FETCH;
				end
				ST_FETCH: state <= ST_DECODE;
				ST_DECODE: begin
					pc <= pc + 1'b1;
					if (fetched.mri.opcode == OP_OPR || fetched.mri.opcode == OP_IOT) begin
						state <= ST_EXEC;
					end else if (fetched.mri.indirect) begin
						state <= ST_DEFER;
					end else begin
						state <= route(fetched.mri.opcode);
						if (fetched.mri.opcode == OP_JMP) begin
							pc <= direct_ea;     // Overrides the increment
						end
					end
				end
				ST_DEFER: if (!defer_wait) begin
					defer_wait <= 1'b1;
				end else begin
					defer_wait <= 1'b0;
					if (is_autoinx) begin
						state <= ST_AUTOINX;
					end else begin
						state <= route(ir.mri.opcode);
						if (ir.mri.opcode == OP_JMP) begin
							pc <= mem.rdata;
						end
					end
				end
				ST_AUTOINX: begin
					state <= route(ir.mri.opcode);
					if (ir.mri.opcode == OP_JMP) begin
						pc <= mb;
					end
				end
				ST_READ: state <= ST_EXEC;
				ST_EXEC: begin
					state <= ST_FETCH;
					case (ir.mri.opcode)
						OP_AND: ac <= ac & mem.rdata;
						OP_TAD: {link, ac} <= {link, ac} + {1'b0, mem.rdata};
						OP_ISZ: state <= ST_WRITE;
						OP_OPR: begin
							ac   <= i_opr_ac;
							link <= i_opr_link;
							if (i_opr_skip) begin
								pc <= pc + 1'b1;
							end
							if (i_opr_halt) begin
								halted <= 1'b1;
								state  <= ST_IDLE;
							end
						end
						default: ;              // IOT does nothing
					endcase
				end
				ST_WRITE: begin
					state <= ST_FETCH;
					case (ir.mri.opcode)
						OP_DCA: ac <= '0;
						OP_JMS: pc <= ma + 1'b1;  // Enter after the link word
						OP_ISZ: if (mb == '0) begin
							pc <= pc + 1'b1;
						end
						default: ;
					endcase
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// IR, MA and MB follow the state
	always_ff @(posedge i_clk) begin
		case (state)
			ST_DECODE: begin
				ir <= fetched;
				ma <= direct_ea;
			end
			ST_DEFER: if (defer_wait) begin
				mb <= mem.rdata + 1'b1;           // Auto-index candidate
				if (!is_autoinx) begin
					ma <= mem.rdata;              // Pointer becomes the target
				end
			end
			ST_AUTOINX: ma <= mb;                 // Use the incremented pointer
			ST_EXEC:    mb <= mem.rdata + 1'b1;   // ISZ result
			default: ;
		endcase
	end

	assign o_instr    = ir;
	assign o_ac_cur   = ac;
	assign o_link_cur = link;
	assign o_run      = (state != ST_IDLE);
	assign o_halted   = halted;
	assign o_pc       = pc;

	// Instruction word came from the address held in PC
	a_fetch_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state == ST_DECODE) |-> ($past(mem.req) && !$past(mem.we) && $past(mem.addr) == pc))
		else $error("fetch address differs from PC");

	// Stopped core leaves memory to the panel
	a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state == ST_IDLE) |-> !mem.req)
		else $error("memory request while idle");

endmodule

// ==== logic/pdp8_top.sv ====
// PDP-8 core top level joining sequencer, operate unit and core memory behind plain ports
`timescale 1ns/1ps
`include "pdp8_defines.svh"

module pdp8_top import pdp8_pkg::*; (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_start,        // Start strobe
	input  logic [0:`PDP8_ADDR_W-1] i_start_pc,     // Start address
	input  logic [0:`PDP8_WORD_W-1] i_switch,       // Switch register
	input  logic                    i_panel_we,     // Panel deposit
	input  logic [0:`PDP8_ADDR_W-1] i_panel_addr,
	input  logic [0:`PDP8_WORD_W-1] i_panel_wdata,
	output logic [0:`PDP8_WORD_W-1] o_panel_rdata,  // Panel examine
	output logic                    o_run,
	output logic                    o_halted,
	output logic [0:`PDP8_ADDR_W-1] o_pc,
	output logic [0:`PDP8_WORD_W-1] o_ac,
	output logic                    o_link
);

	pdp8_mem_if mem_bus ();  // Sequencer to core memory

	instr_u                  instr;     // IR to operate unit
	logic [0:`PDP8_WORD_W-1] opr_ac;
	logic                    opr_link;
	logic                    opr_skip;
	logic                    opr_halt;

	pdp8_memory memory_i (
		.i_clk         (i_clk),
		.mem           (mem_bus.memory),
		.i_panel_we    (i_panel_we),
		.i_panel_addr  (i_panel_addr),
		.i_panel_wdata (i_panel_wdata),
		.o_panel_rdata (o_panel_rdata),
		.i_run         (o_run)
	);

	pdp8_control control_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_start_pc (i_start_pc),
		.mem        (mem_bus.cpu),
		.o_instr    (instr),
		.o_ac_cur   (o_ac),
		.o_link_cur (o_link),
		.i_opr_ac   (opr_ac),
		.i_opr_link (opr_link),
		.i_opr_skip (opr_skip),
		.i_opr_halt (opr_halt),
		.o_run      (o_run),
		.o_halted   (o_halted),
		.o_pc       (o_pc)
	);

	pdp8_operate operate_i (
		.i_instr  (instr),
		.i_ac     (o_ac),
		.i_link   (o_link),
		.i_switch (i_switch),
		.o_ac     (opr_ac),
		.o_link   (opr_link),
		.o_skip   (opr_skip),
		.o_halt   (opr_halt)
	);

endmodule

// ==== sim/pdp8_tb.sv ====
// PDP-8 core testbench that deposits programs over the panel, runs them and checks results
`timescale 1ns/1ps
`include "pdp8_defines.svh"

module pdp8_tb;

	localparam int          timeout_cycles = 4000;     // Longest program needs a few hundred
	localparam logic [11:0] org            = 12'o0200; // Program origin on page 1
	localparam logic [11:0] opnd           = 12'o0263; // Shared operand word
	localparam logic [11:0] cla_cll        = 12'o7300;
	localparam logic [11:0] hlt            = 12'o7402;

	logic                    i_clk;
	logic                    i_rst_n;
	logic                    i_start;
	logic [`PDP8_ADDR_W-1:0] i_start_pc;
	logic [`PDP8_WORD_W-1:0] i_switch;
	logic                    i_panel_we;
	logic [`PDP8_ADDR_W-1:0] i_panel_addr;
	logic [`PDP8_WORD_W-1:0] i_panel_wdata;
	logic [`PDP8_WORD_W-1:0] o_panel_rdata;
	logic                    o_run;
	logic                    o_halted;
	logic [`PDP8_ADDR_W-1:0] o_pc;
	logic [`PDP8_WORD_W-1:0] o_ac;
	logic                    o_link;

	pdp8_top dut_i (.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;  // 8 ns period
	end

	// Running and halted are exclusive
	a_run_halt: assert property (@(posedge i_clk) disable iff (!i_rst_n) !(o_run && o_halted))
		else begin
			$display("o_run and o_halted are both high");
			$display("Checks failed");
			$fatal(1, "status flags conflict");
		end

	// Memory reference word, page bit set when the target is off page zero
	function automatic logic [11:0] mem_ref(input logic [2:0] op, input logic ind,
		input logic [11:0] addr);
		return {op, ind, addr[11:7] != 5'd0, addr[6:0]};
	endfunction

	function automatic logic [12:0] rotate_left(input logic [12:0] v, input int n);
		return (v << n) | (v >> (13 - n));  // Link is bit 12
	endfunction

	// OR of the selected sense tests, reversed by bit 8 (octal 0010)
	function automatic logic skip_expected(input logic [11:0] instr, input logic [11:0] ac,
		input logic link);
		logic cond;
		cond = (instr[6] && ac[11]) || (instr[5] && ac == 12'd0) || (instr[4] && link);
		return cond ^ instr[3];
	endfunction

	task automatic check_val(input string name, input logic [12:0] got, input logic [12:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic deposit(input logic [11:0] addr, input logic [11:0] data);
		@(negedge i_clk);
		i_panel_we    = 1'b1;
		i_panel_addr  = addr;
		i_panel_wdata = data;
		@(negedge i_clk);
		i_panel_we = 1'b0;
	endtask

	task automatic examine(input logic [11:0] addr, output logic [11:0] data);
		@(negedge i_clk);
		i_panel_addr = addr;
		@(negedge i_clk);
		data = o_panel_rdata;  // Registered one cycle after the address
	endtask

	task automatic run_from(input logic [11:0] pc);
		int cycles;
		@(negedge i_clk);
		i_start    = 1'b1;
		i_start_pc = pc;
		@(negedge i_clk);
		i_start = 1'b0;
		assert (o_run && !o_halted) else begin
			$display("the core did not start one cycle after the start strobe");
			$display("Checks failed");
			$fatal(1, "start failed");
		end
		cycles = 0;
		while (!(o_halted && !o_run) && cycles < timeout_cycles) begin
			@(negedge i_clk);
			cycles++;
		end
		if (!(o_halted && !o_run)) begin
			$display("timeout: the core did not halt within %0d cycles", timeout_cycles);
			$display("Checks failed");
			$fatal(1, "run timed out");
		end
	endtask

	initial begin
		logic [11:0] a, b, m, k, v, p, x, sw, word, instr;
		logic [12:0] sum13;
		logic [12:0] exp13;
		logic        l;
		int          n;
		logic [11:0] rot_word [4] = '{12'o7010, 12'o7012, 12'o7004, 12'o7006};  // RAR RTR RAL RTL
		int          rot_left [4] = '{12, 11, 1, 2};
		logic [11:0] skip_word [7] = '{12'o7500, 12'o7440, 12'o7420, 12'o7510,
			12'o7450, 12'o7430, 12'o7410};  // SMA SZA SNL SPA SNA SZL SKP

		void'($urandom(32'h34f7_559b));  // Seed once
		i_rst_n       = 1'b0;
		i_start       = 1'b0;
		i_start_pc    = '0;
		i_switch      = '0;
		i_panel_we    = 1'b0;
		i_panel_addr  = '0;
		i_panel_wdata = '0;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		check_val("o_run", o_run, 0);
		check_val("o_halted", o_halted, 0);
		check_val("o_pc", o_pc, 0);
		check_val("o_ac", o_ac, 0);
		check_val("o_link", o_link, 0);

		// TAD A, TAD B, DCA C, TAD C, AND M, HLT
		a = $urandom;
		b = $urandom;
		m = $urandom;
		deposit(org, cla_cll);
		deposit(org + 1, mem_ref(`PDP8_OP_TAD, 1'b0, 12'o0250));
		deposit(org + 2, mem_ref(`PDP8_OP_TAD, 1'b0, 12'o0251));
		deposit(org + 3, mem_ref(`PDP8_OP_DCA, 1'b0, 12'o0252));
		deposit(org + 4, mem_ref(`PDP8_OP_TAD, 1'b0, 12'o0252));
		deposit(org + 5, mem_ref(`PDP8_OP_AND, 1'b0, 12'o0253));
		deposit(org + 6, hlt);
		deposit(12'o0250, a);
		deposit(12'o0251, b);
		deposit(12'o0253, m);
		run_from(org);
		sum13 = {1'b0, a} + {1'b0, b};
		examine(12'o0252, word);
		check_val("mem C", word, sum13[11:0]);
		check_val("o_link", o_link, sum13[12]);  // Carry out of the sum
		check_val("o_ac", o_ac, sum13[11:0] & m);
		check_val("o_pc", o_pc, org + 7);

		// Counter at minus N, K added per pass
		n = 1 + $urandom % 20;
		k = $urandom;
		deposit(org + 1, mem_ref(`PDP8_OP_TAD, 1'b0, 12'o0260));
		deposit(org + 2, mem_ref(`PDP8_OP_ISZ, 1'b0, 12'o0261));
		deposit(org + 3, mem_ref(`PDP8_OP_JMP, 1'b0, org + 1));  // Back to the TAD
		deposit(org + 4, hlt);
		deposit(12'o0260, k);
		deposit(12'o0261, 12'(-n));
		run_from(org);
		check_val("o_ac", o_ac, 12'(n * k));
		examine(12'o0261, word);
		check_val("counter", word, 0);

		// JMS to 0240, return through JMP I 0240
		v = $urandom;
		deposit(org + 1, mem_ref(`PDP8_OP_JMS, 1'b0, 12'o0240));
		deposit(org + 2, 12'o7001);  // IAC, only reached on return
		deposit(org + 3, hlt);
		deposit(12'o0240, 12'o0000);
		deposit(12'o0241, mem_ref(`PDP8_OP_TAD, 1'b0, opnd));
		deposit(12'o0242, mem_ref(`PDP8_OP_JMP, 1'b1, 12'o0240));
		deposit(opnd, v);
		run_from(org);
		examine(12'o0240, word);
		check_val("entry word", word, org + 2);
		check_val("o_ac", o_ac, 12'(v + 12'd1));
		check_val("o_pc", o_pc, org + 4);

		// Two TAD I 10 through the auto-index pointer
		p = 12'o0300 + 12'($urandom % 48);
		a = $urandom;
		b = $urandom;
		deposit(12'o0010, p);
		deposit(p + 1, a);
		deposit(p + 2, b);
		deposit(org + 1, mem_ref(`PDP8_OP_TAD, 1'b1, 12'o0010));
		deposit(org + 2, mem_ref(`PDP8_OP_TAD, 1'b1, 12'o0010));
		deposit(org + 3, hlt);
		run_from(org);
		check_val("o_ac", o_ac, 12'(a + b));
		examine(12'o0010, word);
		check_val("auto-index word", word, 12'(p + 2));

		// CLA CLL CMA IAC wraps into the link
		deposit(org, 12'o7341);
		deposit(org + 1, hlt);
		run_from(org);
		check_val("o_ac", o_ac, 0);
		check_val("o_link", o_link, 1);

		// Every rotate on a random link and AC
		deposit(org, cla_cll);
		deposit(org + 1, mem_ref(`PDP8_OP_TAD, 1'b0, opnd));
		for (int r = 0; r < 4; r++) begin
			x = $urandom;
			l = $urandom;
			deposit(org + 2, l ? 12'o7020 : 12'o7000);  // CML or NOP
			deposit(org + 3, rot_word[r]);
			deposit(org + 4, hlt);
			deposit(opnd, x);
			run_from(org);
			exp13 = rotate_left({l, x}, rot_left[r]);
			check_val("o_ac", o_ac, exp13[11:0]);
			check_val("o_link", o_link, exp13[12]);
		end

		// Skips over a CML marker, zero AC on about a third of the passes
		for (int s = 0; s < 14; s++) begin
			instr = skip_word[s % 7];
			x     = ($urandom % 3 == 0) ? 12'o0000 : 12'($urandom);
			l     = $urandom;
			deposit(org + 2, l ? 12'o7020 : 12'o7000);
			deposit(org + 3, instr);
			deposit(org + 4, 12'o7020);  // Marker flips the link when not skipped
			deposit(org + 5, hlt);
			deposit(opnd, x);
			run_from(org);
			check_val("o_ac", o_ac, x);
			check_val("o_link", o_link, skip_expected(instr, x, l) ? l : !l);
			check_val("o_pc", o_pc, org + 6);
		end

		// CLA OSR reads the switch register
		x  = $urandom;
		sw = $urandom;
		i_switch = sw;
		deposit(org + 2, 12'o7604);
		deposit(org + 3, hlt);
		deposit(opnd, x);
		run_from(org);
		check_val("o_ac", o_ac, sw);

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/pdp8_pkg.sv
logic/pdp8_mem_if.sv
logic/pdp8_memory.sv
logic/pdp8_operate.sv
logic/pdp8_control.sv
logic/pdp8_top.sv
sim/pdp8_tb.sv

// ==== Bender.yml ====
package:
  name: pdp8

sources:
  - include_dirs:
      - logic
    files:
      - logic/pdp8_pkg.sv
      - logic/pdp8_mem_if.sv
      - logic/pdp8_memory.sv
      - logic/pdp8_operate.sv
      - logic/pdp8_control.sv
      - logic/pdp8_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/pdp8_tb.sv
